// ==== ext_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

// Circular valid/ready buffer
// Pop happens where valid_o and ready_i are both high
module ext_buffer
#(
   parameter int unsigned DATA_WIDTH   = 32,
   parameter int unsigned BUFFER_DEPTH = 2
)
(
   input  logic                  clk_i,
   input  logic                  rst_ni,

   // Push side
   input  logic                  valid_i,
   input  logic [DATA_WIDTH-1:0] data_i,
   output logic                  ready_o,

   // Pop side
   output logic [DATA_WIDTH-1:0] data_o,
   output logic                  valid_o,
   input  logic                  ready_i
);

   // Pointer and count widths
   localparam int unsigned PTR_W = (BUFFER_DEPTH > 1) ? $clog2(BUFFER_DEPTH) : 1;
   localparam int unsigned CNT_W = $clog2(BUFFER_DEPTH + 1);

   logic [PTR_W-1:0]      ptr_in_q;
   logic [PTR_W-1:0]      ptr_out_q;
   logic [CNT_W-1:0]      count_q;
   logic [DATA_WIDTH-1:0] storage_q [BUFFER_DEPTH];
   logic                  full;
   logic                  push;
   logic                  pop;

   // -------------------------------------------------------------------------
   // Handshake decode
   // -------------------------------------------------------------------------
   assign full = (count_q == CNT_W'(BUFFER_DEPTH));
   // A full buffer refuses input even when popping this cycle
   assign push = valid_i && !full;
   assign pop  = valid_o && ready_i;

   // Element count
   always_ff @(posedge clk_i or negedge rst_ni)
   begin : count_reg
      if (!rst_ni)
         count_q <= '0;
      // One out, none in
      else if (pop && !push)
         count_q <= count_q - 1'b1;
      // One in, none out
      else if (push && !pop)
         count_q <= count_q + 1'b1;
      // Both or neither, count holds
   end

   // -------------------------------------------------------------------------
   // Wrapping pointers
   // -------------------------------------------------------------------------
   always_ff @(posedge clk_i or negedge rst_ni)
   begin : ptr_reg
      if (!rst_ni)
      begin
         ptr_in_q  <= '0;
         ptr_out_q <= '0;
      end
      else
      begin
         // Next free slot
         if (push)
            ptr_in_q <= (ptr_in_q == PTR_W'(BUFFER_DEPTH - 1)) ? '0 : ptr_in_q + 1'b1;
         // Next entry to hand out
         if (pop)
            ptr_out_q <= (ptr_out_q == PTR_W'(BUFFER_DEPTH - 1)) ? '0 : ptr_out_q + 1'b1;
      end
   end

   // Entry storage
   always_ff @(posedge clk_i)
   begin : storage_write
      if (push)
         storage_q[ptr_in_q] <= data_i;
   end

   // Outputs
   assign data_o  = storage_q[ptr_out_q];
   assign valid_o = (count_q != '0);   // eligible the cycle after push
   assign ready_o = !full;

   // -------------------------------------------------------------------------
   // Checks
   // -------------------------------------------------------------------------
   // Full without a pop keeps its head entry, so nothing was pushed over it
   a_no_push_when_full : assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      (full && !pop) |=> (full && $stable(data_o))
   );

   // Pointers meet only when the buffer is empty or full
   a_ptr_count_match : assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      (ptr_in_q == ptr_out_q) == ((count_q == '0) || full)
   );

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+.
mem_pkg.sv
ext_buffer.sv
rr_arbiter.sv
sram_bank.sv
resp_router.sv
mem_subsystem_top.sv
tb_mem_subsystem.sv

// ==== mem_params.svh ====
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// Word address width of the shared bank
`define MEM_ADDR_W 8

// Data word width
`define MEM_DATA_W 32

// Peer request ports sharing the bank
`define MEM_N_MASTERS 2

// Entries held by each request buffer
`define MEM_BUF_DEPTH 2

// Words in the bank, one per address
`define MEM_WORDS 256

`endif

// ==== mem_pkg.sv ====
`default_nettype none

`include "mem_params.svh"

package mem_pkg;

   // Master index width, never below one bit
   localparam int unsigned MASTER_ID_W = (`MEM_N_MASTERS > 1) ? $clog2(`MEM_N_MASTERS) : 1;

   // Field positions inside a request word
   localparam int unsigned REQ_WE_BIT   = `MEM_ADDR_W + `MEM_DATA_W;
   localparam int unsigned REQ_ADDR_LSB = `MEM_DATA_W;

   // Word address into the bank
   typedef logic [`MEM_ADDR_W-1:0] addr_t;

   // Data word
   typedef logic [`MEM_DATA_W-1:0] data_t;

   // Packed request of write flag, address and write data, MSB first
   typedef logic [`MEM_ADDR_W+`MEM_DATA_W:0] req_t;

   // Index of one master
   typedef logic [MASTER_ID_W-1:0] master_id_t;

   // One bit per master
   typedef logic [`MEM_N_MASTERS-1:0] master_vec_t;

   // Master that currently holds highest priority
   typedef enum logic [MASTER_ID_W-1:0] {
      PRIO_M0,
      PRIO_M1
   } arb_state_e;

endpackage

`default_nettype wire

// ==== mem_subsystem_tests.txt ====
# test(dec) master we addr(hex) wdata(hex) gap(hex, ff picks a random gap of 0 to 3 cycles)
# master 0 stays in 00-7f and master 1 in 80-ff, read lines carry zero wdata
1 0 0 10 00000000 0
2 0 1 11 a5a50011 0
3 0 0 11 00000000 0
4 0 1 12 deadbeef 0
5 0 1 13 01234567 0
6 0 0 12 00000000 0
7 0 0 13 00000000 ff
8 0 1 11 5a5a1111 ff
9 0 0 11 00000000 ff
10 0 0 7f 00000000 ff
11 0 1 20 c0ffee00 2
12 0 0 20 00000000 0
13 0 0 14 00000000 1
14 1 0 90 00000000 0
15 1 1 91 11112222 0
16 1 0 91 00000000 0
17 1 1 92 89abcdef 0
18 1 1 93 fedcba98 0
19 1 0 92 00000000 0
20 1 0 93 00000000 ff
21 1 1 91 33334444 ff
22 1 0 91 00000000 ff
23 1 0 ff 00000000 ff
24 1 1 a0 0badf00d 1
25 1 0 a0 00000000 0
26 1 0 94 00000000 2

// ==== mem_subsystem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

// Shared bank behind per-master request buffers
module mem_subsystem_top
(
   input  logic                                clk_i,
   input  logic                                rst_ni,

   // Request side, one lane per master
   input  mem_pkg::master_vec_t                req_valid_i,
   input  mem_pkg::master_vec_t                req_we_i,
   input  mem_pkg::addr_t [`MEM_N_MASTERS-1:0] req_addr_i,
   input  mem_pkg::data_t [`MEM_N_MASTERS-1:0] req_wdata_i,
   output mem_pkg::master_vec_t                req_ready_o,

   // Response side, no back-pressure
   output mem_pkg::master_vec_t                rsp_valid_o,
   output mem_pkg::data_t [`MEM_N_MASTERS-1:0] rsp_rdata_o
);

   mem_pkg::req_t [`MEM_N_MASTERS-1:0] buf_req_in;
   mem_pkg::req_t [`MEM_N_MASTERS-1:0] buf_req_out;
   mem_pkg::master_vec_t               buf_valid;
   mem_pkg::master_vec_t               gnt;
   mem_pkg::master_id_t                gnt_id;
   logic                               bank_en;
   mem_pkg::req_t                      bank_req;
   mem_pkg::data_t                     bank_rdata;

   // -------------------------------------------------------------------------
   // Request buffers
   // -------------------------------------------------------------------------
   generate
      for (genvar m = 0; m < `MEM_N_MASTERS; m++)
      begin : g_master
         // Pack write flag, address and data
         assign buf_req_in[m] = {req_we_i[m], req_addr_i[m], req_wdata_i[m]};

         // Grant bit doubles as the pop handshake
         ext_buffer
         #(
            .DATA_WIDTH   ($bits(mem_pkg::req_t)),
            .BUFFER_DEPTH (`MEM_BUF_DEPTH)
         )
         buf_i
         (
            .clk_i   (clk_i),
            .rst_ni  (rst_ni),
            .valid_i (req_valid_i[m]),
            .data_i  (buf_req_in[m]),
            .ready_o (req_ready_o[m]),
            .data_o  (buf_req_out[m]),
            .valid_o (buf_valid[m]),
            .ready_i (gnt[m])
         );
      end
   endgenerate

   // -------------------------------------------------------------------------
   // Arbitration and bank
   // -------------------------------------------------------------------------
   rr_arbiter arb_i
   (
      .clk_i     (clk_i),
      .rst_ni    (rst_ni),
      .req_i     (buf_valid),
      .gnt_o     (gnt),
      .gnt_id_o  (gnt_id),
      .bank_en_o (bank_en)
   );

   // Head of the granted buffer
   assign bank_req = buf_req_out[gnt_id];

   sram_bank bank_i
   (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .en_i    (bank_en),
      .req_i   (bank_req),
      .rdata_o (bank_rdata)
   );

   // Response back to the owner one cycle after grant
   resp_router router_i
   (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .gnt_i       (gnt),
      .rdata_i     (bank_rdata),
      .rsp_valid_o (rsp_valid_o),
      .rsp_rdata_o (rsp_rdata_o)
   );

endmodule

`default_nettype wire

// ==== resp_router.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

// Returns a one-cycle response strobe with read data to the granted master
module resp_router
(
   input  logic                                clk_i,
   input  logic                                rst_ni,
   input  mem_pkg::master_vec_t                gnt_i,
   input  mem_pkg::data_t                      rdata_i,
   output mem_pkg::master_vec_t                rsp_valid_o,
   output mem_pkg::data_t [`MEM_N_MASTERS-1:0] rsp_rdata_o
);

   // Grant of the access now leaving the bank
   mem_pkg::master_vec_t gnt_q;

   // Lines up with the bank read register
   always_ff @(posedge clk_i or negedge rst_ni)
   begin : gnt_reg
      if (!rst_ni)
         gnt_q <= '0;
      else
         gnt_q <= gnt_i;
   end

   // One pulse per granted access
   assign rsp_valid_o = gnt_q;

   // Data lane of the owner, zero elsewhere
   always_comb
   begin : lane_select
      for (int m = 0; m < `MEM_N_MASTERS; m++)
         rsp_rdata_o[m] = gnt_q[m] ? rdata_i : '0;
   end

   // -------------------------------------------------------------------------
   // Checks
   // -------------------------------------------------------------------------
   // Never more than one master answered per cycle
   a_rsp_onehot : assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      $onehot0(rsp_valid_o)
   );

endmodule

`default_nettype wire

// ==== rr_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

// Round-robin grant of the bank, one buffered request per cycle
module rr_arbiter
(
   input  logic                 clk_i,
   input  logic                 rst_ni,
   input  mem_pkg::master_vec_t req_i,
   output mem_pkg::master_vec_t gnt_o,
   output mem_pkg::master_id_t  gnt_id_o,
   output logic                 bank_en_o
);

   mem_pkg::arb_state_e prio_q;
   mem_pkg::arb_state_e prio_d;

   // -------------------------------------------------------------------------
   // Grant search
   // -------------------------------------------------------------------------
   // Scan from the priority master, first requester wins
   always_comb
   begin : grant_search
      int   idx;
      logic found;
      found    = 1'b0;
      gnt_o    = '0;
      gnt_id_o = '0;
      for (int i = 0; i < `MEM_N_MASTERS; i++)
      begin
         idx = (int'(prio_q) + i) % `MEM_N_MASTERS;
         if (!found && req_i[idx])
         begin
            found      = 1'b1;
            gnt_o[idx] = 1'b1;
            gnt_id_o   = mem_pkg::master_id_t'(idx);
         end
      end
   end

   // Bank access whenever any buffer is granted
   assign bank_en_o = |gnt_o;

   // Priority passes to the master after the one granted
   always_comb
   begin : prio_next
      if (gnt_id_o == mem_pkg::master_id_t'(`MEM_N_MASTERS - 1))
         prio_d = mem_pkg::PRIO_M0;
      else
         prio_d = mem_pkg::arb_state_e'(gnt_id_o + 1'b1);
   end

   // Priority register, moves only on a grant
   always_ff @(posedge clk_i or negedge rst_ni)
   begin : prio_reg
      if (!rst_ni)
         prio_q <= mem_pkg::PRIO_M0;
      else if (bank_en_o)
         prio_q <= prio_d;
   end

   // -------------------------------------------------------------------------
   // Checks
   // -------------------------------------------------------------------------
   // At most one grant, and only to a requester
   a_gnt_legal : assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      $onehot0(gnt_o) && ((gnt_o & ~req_i) == '0)
   );

   // With every master requesting, the same master never wins twice in a row
   a_gnt_rotates : assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      (bank_en_o ##1 (&req_i)) |-> ((gnt_o & $past(gnt_o)) == '0)
   );

endmodule

`default_nettype wire

// ==== sram_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

// Single-port bank with registered read data
module sram_bank
(
   input  logic           clk_i,
   input  logic           rst_ni,
   input  logic           en_i,
   input  mem_pkg::req_t  req_i,
   output mem_pkg::data_t rdata_o
);

   mem_pkg::data_t mem_q [`MEM_WORDS];
   logic           we;
   mem_pkg::addr_t addr;
   mem_pkg::data_t wdata;

   // -------------------------------------------------------------------------
   // Request fields
   // -------------------------------------------------------------------------
   assign we    = req_i[mem_pkg::REQ_WE_BIT];
   assign addr  = req_i[mem_pkg::REQ_ADDR_LSB +: `MEM_ADDR_W];
   assign wdata = req_i[`MEM_DATA_W-1:0];

   // -------------------------------------------------------------------------
   // Access
   // -------------------------------------------------------------------------
   // Reset clears every word so unwritten reads return zero
   // Read sees the word from before this edge
   // Write echoes its own data on the read register
   always_ff @(posedge clk_i or negedge rst_ni)
   begin : bank_access
      if (!rst_ni)
      begin
         for (int w = 0; w < `MEM_WORDS; w++)
            mem_q[w] <= '0;
         rdata_o <= '0;
      end
      else if (en_i)
      begin
         if (we)
         begin
            mem_q[addr] <= wdata;
            rdata_o     <= wdata;
         end
         else
         begin
            rdata_o <= mem_q[addr];
         end
      end
   end

endmodule

`default_nettype wire

// ==== tb_mem_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module tb_mem_subsystem;

   localparam int CLK_PERIOD = 40;
   localparam int DRIVE_DLY  = 2;
   localparam int MAX_TESTS  = 64;
   localparam int N          = `MEM_N_MASTERS;

   // DUT ports
   logic                                clk_i;
   logic                                rst_ni;
   mem_pkg::master_vec_t                req_valid_i;
   mem_pkg::master_vec_t                req_we_i;
   mem_pkg::addr_t [`MEM_N_MASTERS-1:0] req_addr_i;
   mem_pkg::data_t [`MEM_N_MASTERS-1:0] req_wdata_i;
   mem_pkg::master_vec_t                req_ready_o;
   mem_pkg::master_vec_t                rsp_valid_o;
   mem_pkg::data_t [`MEM_N_MASTERS-1:0] rsp_rdata_o;

   // Test table as read from the tests file
   int             n_tests;
   int             t_num    [MAX_TESTS];
   int             t_master [MAX_TESTS];
   logic           t_we     [MAX_TESTS];
   mem_pkg::addr_t t_addr   [MAX_TESTS];
   mem_pkg::data_t t_wdata  [MAX_TESTS];
   int             t_gap    [MAX_TESTS];

   // Model memory and per-master expected queues, filled in issue order
   mem_pkg::data_t       model_mem [`MEM_WORDS];
   int                   exp_test  [N][MAX_TESTS];
   mem_pkg::data_t       exp_data  [N][MAX_TESTS];
   int                   acc_cnt   [N];
   int                   rsp_cnt   [N];
   int                   rsp_total;
   // Round-robin model state
   mem_pkg::master_vec_t pred_rsp;
   int                   prio;
   int                   last_rsp_master;
   int                   alt_cnt;
   // Bookkeeping
   mem_pkg::master_vec_t stall_seen;
   mem_pkg::master_vec_t drv_done;
   logic                 run;
   int                   pass_cnt;
   int                   fail_cnt;
   integer               seed;

   mem_subsystem_top dut_i
   (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .req_valid_i (req_valid_i),
      .req_we_i    (req_we_i),
      .req_addr_i  (req_addr_i),
      .req_wdata_i (req_wdata_i),
      .req_ready_o (req_ready_o),
      .rsp_valid_o (rsp_valid_o),
      .rsp_rdata_o (rsp_rdata_o)
   );

   initial clk_i = 1'b0;
   always #(CLK_PERIOD/2) clk_i = ~clk_i;

   // -------------------------------------------------------------------------
   // Tests file
   // -------------------------------------------------------------------------
   task automatic load_tests();
      integer              fd;
      integer              code;
      logic [8*128-1:0]    line;
      int                  num;
      int                  m;
      int                  we;
      int                  gap;
      logic [31:0]         addr;
      logic [31:0]         wdata;
      n_tests = 0;
      fd = $fopen("mem_subsystem_tests.txt", "r");
      if (fd == 0)
      begin
         $display("Could not open the tests file mem_subsystem_tests.txt");
         fail_cnt++;
      end
      else
      begin
         while (!$feof(fd) && n_tests < MAX_TESTS)
         begin
            code = $fgets(line, fd);
            // Comment lines match no field and drop out here
            if (code != 0)
               code = $sscanf(line, "%d %h %h %h %h %h", num, m, we, addr, wdata, gap);
            if (code == 6)
            begin
               t_num[n_tests]    = num;
               t_master[n_tests] = m;
               t_we[n_tests]     = (we != 0);
               t_addr[n_tests]   = addr[`MEM_ADDR_W-1:0];
               t_wdata[n_tests]  = wdata[`MEM_DATA_W-1:0];
               // Random gap drawn here so the sequence is fixed by file order
               if (gap == 'hff)
                  t_gap[n_tests] = $unsigned($random(seed)) % 4;
               else
                  t_gap[n_tests] = gap;
               n_tests++;
            end
         end
         $fclose(fd);
      end
   endtask

   // -------------------------------------------------------------------------
   // Request side
   // -------------------------------------------------------------------------
   // Expected response of an accepted request, from the model memory
   task automatic record_issue(input int m, input int k);
      if (t_we[k])
         model_mem[t_addr[k]] = t_wdata[k];
      exp_test[m][acc_cnt[m]] = k;
      exp_data[m][acc_cnt[m]] = model_mem[t_addr[k]];
      acc_cnt[m]++;
   endtask

   // Issues one master's lines in file order, holding valid until accepted
   task automatic drive_master(input int m);
      logic accepted;
      for (int k = 0; k < n_tests; k++)
      begin
         if (t_master[k] == m)
         begin
            req_valid_i[m] = 1'b1;
            req_we_i[m]    = t_we[k];
            req_addr_i[m]  = t_addr[k];
            req_wdata_i[m] = t_wdata[k];
            accepted = 1'b0;
            while (!accepted)
            begin
               // Ready is stable mid-cycle and decides the coming edge
               @(negedge clk_i);
               accepted = req_ready_o[m];
               if (!accepted)
                  stall_seen[m] = 1'b1;
               @(posedge clk_i);
               #(DRIVE_DLY);
            end
            record_issue(m, k);
            req_valid_i[m] = 1'b0;
            repeat (t_gap[k])
            begin
               @(posedge clk_i);
               #(DRIVE_DLY);
            end
         end
      end
      drv_done[m] = 1'b1;
   endtask

   for (genvar g = 0; g < N; g++)
   begin : g_driver
      initial
      begin
         wait (run === 1'b1);
         drive_master(g);
      end
   end

   // -------------------------------------------------------------------------
   // Response side
   // -------------------------------------------------------------------------
   task automatic check_response(input int m);
      int k;
      if (rsp_cnt[m] >= acc_cnt[m])
      begin
         $display("Response pulse for master %0d with no request outstanding", m);
         fail_cnt++;
      end
      else
      begin
         k = exp_test[m][rsp_cnt[m]];
         if (rsp_rdata_o[m] !== exp_data[m][rsp_cnt[m]])
         begin
            $display("[ERROR] rsp_rdata_o[%0d]: expected %h, actual %h",
                     m, exp_data[m][rsp_cnt[m]], rsp_rdata_o[m]);
            $display("test %0d master %0d addr %h: FAIL", t_num[k], m, t_addr[k]);
            fail_cnt++;
         end
         else
         begin
            $display("test %0d master %0d %s addr %h data %h: ok", t_num[k], m,
                     t_we[k] ? "write" : "read ", t_addr[k], rsp_rdata_o[m]);
            pass_cnt++;
         end
         rsp_cnt[m]++;
         rsp_total++;
      end
   endtask

   // Grant this cycle, from requests still waiting in the buffers
   // Highest priority master first, priority passes past the winner
   task automatic predict_grant();
      int   start;
      int   cand;
      logic found;
      start    = prio;
      found    = 1'b0;
      pred_rsp = '0;
      for (int i = 0; i < N; i++)
      begin
         cand = (start + i) % N;
         if (!found && (acc_cnt[cand] > rsp_cnt[cand]))
         begin
            found          = 1'b1;
            pred_rsp[cand] = 1'b1;
            prio           = (cand + 1) % N;
         end
      end
   endtask

   // Outputs sampled mid-cycle where they are settled
   always @(negedge clk_i)
   begin : response_check
      int pulse_master;
      if (rst_ni === 1'b1)
      begin
         if (rsp_valid_o !== pred_rsp)
         begin
            $display("[ERROR] rsp_valid_o: expected %h, actual %h", pred_rsp, rsp_valid_o);
            fail_cnt++;
         end
         pulse_master = -1;
         for (int m = 0; m < N; m++)
         begin
            if (rsp_valid_o[m])
            begin
               check_response(m);
               pulse_master = m;
            end
            else if (rsp_rdata_o[m] !== '0)
            begin
               $display("[ERROR] rsp_rdata_o[%0d]: expected %h, actual %h",
                        m, mem_pkg::data_t'(0), rsp_rdata_o[m]);
               fail_cnt++;
            end
         end
         // Back-to-back pulses to different masters
         if (pulse_master >= 0 && last_rsp_master >= 0 && pulse_master != last_rsp_master)
            alt_cnt++;
         last_rsp_master = pulse_master;
         predict_grant();
      end
   end

   // Run limit scales with the number of tests
   initial
   begin : watchdog
      wait (run === 1'b1);
      #((n_tests + 20) * 8 * CLK_PERIOD);
      $display("Timeout: %0d of %0d responses arrived, the rest are missing",
               rsp_total, n_tests);
      $display("Simulation finished: FAIL");
      $finish;
   end

   // -------------------------------------------------------------------------
   // Main sequence
   // -------------------------------------------------------------------------
   initial
   begin : main
      mem_pkg::master_vec_t all_ready;
      all_ready       = '1;
      rst_ni          = 1'b0;
      req_valid_i     = '0;
      req_we_i        = '0;
      req_addr_i      = '0;
      req_wdata_i     = '0;
      run             = 1'b0;
      drv_done        = '0;
      stall_seen      = '0;
      pred_rsp        = '0;
      prio            = 0;
      last_rsp_master = -1;
      alt_cnt         = 0;
      rsp_total       = 0;
      pass_cnt        = 0;
      fail_cnt        = 0;
      seed            = 32'h6c85_3323;
      for (int w = 0; w < `MEM_WORDS; w++)
         model_mem[w] = '0;
      for (int m = 0; m < N; m++)
      begin
         acc_cnt[m] = 0;
         rsp_cnt[m] = 0;
      end
      load_tests();

      repeat (3) @(posedge clk_i);
      #(DRIVE_DLY);
      rst_ni = 1'b1;

      // Idle state after reset, before any request
      @(negedge clk_i);
      if (req_ready_o !== all_ready)
      begin
         $display("[ERROR] req_ready_o: expected %h, actual %h", all_ready, req_ready_o);
         fail_cnt++;
      end
      if (rsp_valid_o !== '0)
      begin
         $display("[ERROR] rsp_valid_o: expected %h, actual %h", 
                  mem_pkg::master_vec_t'(0), rsp_valid_o);
         fail_cnt++;
      end
      @(posedge clk_i);
      #(DRIVE_DLY);
      run = 1'b1;

      wait (drv_done == all_ready);
      while (rsp_total < n_tests)
         @(negedge clk_i);
      // Idle cycles catch stray pulses
      repeat (4) @(negedge clk_i);

      if (stall_seen == '0)
      begin
         $display("Back-pressure never seen, req_ready_o stayed high for every master");
         fail_cnt++;
      end
      if (alt_cnt == 0)
      begin
         $display("No alternating responses seen under contention");
         fail_cnt++;
      end

      $display("Passed: %0d  Failed: %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

`default_nettype wire
